//--- logic/aes_pkg.sv
`default_nettype none

package aes_pkg;

    // ========================================================================
    // Sizes and types
    // ========================================================================

    localparam int block_bits = 128;
    localparam int word_bits  = 32;
    localparam int byte_bits  = 8;
    localparam int num_rounds = 10;

    typedef logic [block_bits-1:0] block_t;
    typedef logic [word_bits-1:0]  word_t;
    typedef logic [3:0]            round_idx_t;

    typedef enum logic [1:0] {
        phase_load,
        phase_middle,
        phase_final,
        phase_idle
    } round_phase_t;

    typedef struct packed {
        round_phase_t phase;
        round_idx_t   key_index;
    } round_ctrl_t;

    // ========================================================================
    // Lookup tables
    // ========================================================================

    // Forward S-box, key expansion only
    localparam logic [byte_bits-1:0] sbox_table [0:255] = '{
        8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
        8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
        8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
        8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
        8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
        8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
        8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
        8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
        8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
        8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
        8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
        8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
        8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
        8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
        8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
        8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
        8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
        8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
        8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
        8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
        8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
        8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
        8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
        8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
        8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
        8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
        8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
        8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
        8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
        8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
        8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
        8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
    };

    localparam logic [byte_bits-1:0] inv_sbox_table [0:255] = '{
        8'h52, 8'h09, 8'h6a, 8'hd5, 8'h30, 8'h36, 8'ha5, 8'h38,
        8'hbf, 8'h40, 8'ha3, 8'h9e, 8'h81, 8'hf3, 8'hd7, 8'hfb,
        8'h7c, 8'he3, 8'h39, 8'h82, 8'h9b, 8'h2f, 8'hff, 8'h87,
        8'h34, 8'h8e, 8'h43, 8'h44, 8'hc4, 8'hde, 8'he9, 8'hcb,
        8'h54, 8'h7b, 8'h94, 8'h32, 8'ha6, 8'hc2, 8'h23, 8'h3d,
        8'hee, 8'h4c, 8'h95, 8'h0b, 8'h42, 8'hfa, 8'hc3, 8'h4e,
        8'h08, 8'h2e, 8'ha1, 8'h66, 8'h28, 8'hd9, 8'h24, 8'hb2,
        8'h76, 8'h5b, 8'ha2, 8'h49, 8'h6d, 8'h8b, 8'hd1, 8'h25,
        8'h72, 8'hf8, 8'hf6, 8'h64, 8'h86, 8'h68, 8'h98, 8'h16,
        8'hd4, 8'ha4, 8'h5c, 8'hcc, 8'h5d, 8'h65, 8'hb6, 8'h92,
        8'h6c, 8'h70, 8'h48, 8'h50, 8'hfd, 8'hed, 8'hb9, 8'hda,
        8'h5e, 8'h15, 8'h46, 8'h57, 8'ha7, 8'h8d, 8'h9d, 8'h84,
        8'h90, 8'hd8, 8'hab, 8'h00, 8'h8c, 8'hbc, 8'hd3, 8'h0a,
        8'hf7, 8'he4, 8'h58, 8'h05, 8'hb8, 8'hb3, 8'h45, 8'h06,
        8'hd0, 8'h2c, 8'h1e, 8'h8f, 8'hca, 8'h3f, 8'h0f, 8'h02,
        8'hc1, 8'haf, 8'hbd, 8'h03, 8'h01, 8'h13, 8'h8a, 8'h6b,
        8'h3a, 8'h91, 8'h11, 8'h41, 8'h4f, 8'h67, 8'hdc, 8'hea,
        8'h97, 8'hf2, 8'hcf, 8'hce, 8'hf0, 8'hb4, 8'he6, 8'h73,
        8'h96, 8'hac, 8'h74, 8'h22, 8'he7, 8'had, 8'h35, 8'h85,
        8'he2, 8'hf9, 8'h37, 8'he8, 8'h1c, 8'h75, 8'hdf, 8'h6e,
        8'h47, 8'hf1, 8'h1a, 8'h71, 8'h1d, 8'h29, 8'hc5, 8'h89,
        8'h6f, 8'hb7, 8'h62, 8'h0e, 8'haa, 8'h18, 8'hbe, 8'h1b,
        8'hfc, 8'h56, 8'h3e, 8'h4b, 8'hc6, 8'hd2, 8'h79, 8'h20,
        8'h9a, 8'hdb, 8'hc0, 8'hfe, 8'h78, 8'hcd, 8'h5a, 8'hf4,
        8'h1f, 8'hdd, 8'ha8, 8'h33, 8'h88, 8'h07, 8'hc7, 8'h31,
        8'hb1, 8'h12, 8'h10, 8'h59, 8'h27, 8'h80, 8'hec, 8'h5f,
        8'h60, 8'h51, 8'h7f, 8'ha9, 8'h19, 8'hb5, 8'h4a, 8'h0d,
        8'h2d, 8'he5, 8'h7a, 8'h9f, 8'h93, 8'hc9, 8'h9c, 8'hef,
        8'ha0, 8'he0, 8'h3b, 8'h4d, 8'hae, 8'h2a, 8'hf5, 8'hb0,
        8'hc8, 8'heb, 8'hbb, 8'h3c, 8'h83, 8'h53, 8'h99, 8'h61,
        8'h17, 8'h2b, 8'h04, 8'h7e, 8'hba, 8'h77, 8'hd6, 8'h26,
        8'he1, 8'h69, 8'h14, 8'h63, 8'h55, 8'h21, 8'h0c, 8'h7d
    };

    localparam logic [byte_bits-1:0] rcon_table [0:num_rounds-1] = '{
        8'h01, 8'h02, 8'h04, 8'h08, 8'h10, 8'h20, 8'h40, 8'h80, 8'h1b, 8'h36
    };

    // ========================================================================
    // GF(2^8) arithmetic
    // ========================================================================

    function automatic logic [byte_bits-1:0] xtime(input logic [byte_bits-1:0] b);
        return b[7] ? ((b << 1) ^ 8'h1b) : (b << 1);
    endfunction

    // Shift-and-add over the four bits of the constant
    function automatic logic [byte_bits-1:0] gf_mul(input logic [byte_bits-1:0] a,
                                                    input logic [3:0] m);
        logic [byte_bits-1:0] prod;
        logic [byte_bits-1:0] acc;
        prod = '0;
        acc  = a;
        for (int i = 0; i < 4; i++)
        begin
            if (m[i])
                prod ^= acc;
            acc = xtime(acc);
        end
        return prod;
    endfunction

    function automatic word_t inv_mix_column(input word_t col);
        logic [byte_bits-1:0] a0, a1, a2, a3;
        logic [byte_bits-1:0] b0, b1, b2, b3;
        a0 = col[31:24];
        a1 = col[23:16];
        a2 = col[15:8];
        a3 = col[7:0];
        b0 = gf_mul(a0, 4'he) ^ gf_mul(a1, 4'hb) ^ gf_mul(a2, 4'hd) ^ gf_mul(a3, 4'h9);
        b1 = gf_mul(a0, 4'h9) ^ gf_mul(a1, 4'he) ^ gf_mul(a2, 4'hb) ^ gf_mul(a3, 4'hd);
        b2 = gf_mul(a0, 4'hd) ^ gf_mul(a1, 4'h9) ^ gf_mul(a2, 4'he) ^ gf_mul(a3, 4'hb);
        b3 = gf_mul(a0, 4'hb) ^ gf_mul(a1, 4'hd) ^ gf_mul(a2, 4'h9) ^ gf_mul(a3, 4'he);
        return {b0, b1, b2, b3};
    endfunction

endpackage

`default_nettype wire

//--- logic/aes_round_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module aes_round_ctrl
    import aes_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    output round_ctrl_t ctrl
);

    round_idx_t count;

    // ========================================================================
    // Round counter, saturates one past the final round
    // ========================================================================

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            count <= '0;
        end
        else if (count != round_idx_t'(num_rounds + 1))
        begin
            count <= count + 1'b1;
        end
    end

    // ========================================================================
    // Phase decode
    // ========================================================================

    always_comb
    begin
        ctrl.phase     = phase_idle;
        ctrl.key_index = '0;
        if (count == '0)
        begin
            ctrl.phase     = phase_load;
            ctrl.key_index = round_idx_t'(num_rounds);
        end
        else if (count < round_idx_t'(num_rounds))
        begin
            // Keys are consumed from the end of the schedule
            ctrl.phase     = phase_middle;
            ctrl.key_index = round_idx_t'(num_rounds) - count;
        end
        else if (count == round_idx_t'(num_rounds))
        begin
            ctrl.phase     = phase_final;
            ctrl.key_index = '0;
        end
    end

endmodule

`default_nettype wire

//--- logic/aes_key_schedule.sv
`timescale 1ns/1ps
`default_nettype none

module aes_key_schedule
    import aes_pkg::*;
(
    input  block_t      key,
    input  round_ctrl_t ctrl,
    output block_t      round_key
);

    localparam int num_words = 4 * (num_rounds + 1);

    word_t  w  [0:num_words-1];
    block_t rk [0:num_rounds];

    genvar i;

    // ========================================================================
    // Word expansion
    // ========================================================================

    generate
        for (i = 0; i < num_words; i++)
        begin : g_word
            if (i < 4)
            begin : g_seed
                assign w[i] = key[block_bits-1-word_bits*i -: word_bits];
            end
            else if (i % 4 == 0)
            begin : g_core
                word_t rot;
                // RotWord then SubWord with Rcon on the top byte
                assign rot  = {w[i-1][23:0], w[i-1][31:24]};
                assign w[i] = w[i-4] ^ {sbox_table[rot[31:24]] ^ rcon_table[i/4-1],
                                        sbox_table[rot[23:16]],
                                        sbox_table[rot[15:8]],
                                        sbox_table[rot[7:0]]};
            end
            else
            begin : g_chain
                assign w[i] = w[i-4] ^ w[i-1];
            end
        end

        for (i = 0; i <= num_rounds; i++)
        begin : g_round_key
            assign rk[i] = {w[4*i], w[4*i+1], w[4*i+2], w[4*i+3]};
        end
    endgenerate

    // Round key numbered by the control index
    assign round_key = rk[ctrl.key_index];

endmodule

`default_nettype wire

//--- logic/aes_inv_round.sv
`timescale 1ns/1ps
`default_nettype none

module aes_inv_round
    import aes_pkg::*;
(
    input  block_t      state,
    input  block_t      ciphertext,
    input  block_t      round_key,
    input  round_ctrl_t ctrl,
    output block_t      next_state
);

    block_t shifted;
    block_t subbed;
    block_t keyed;
    block_t mixed;

    // ========================================================================
    // InvShiftRows and InvSubBytes
    // ========================================================================

    // Byte k of the block sits at column k/4 and row k%4 with MSB first
    always_comb
    begin
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
            begin
                shifted[block_bits-1-byte_bits*(4*c+r) -: byte_bits] =
                    state[block_bits-1-byte_bits*(4*((c-r+4)%4)+r) -: byte_bits];
            end
        end
    end

    always_comb
    begin
        for (int k = 0; k < 16; k++)
        begin
            subbed[block_bits-1-byte_bits*k -: byte_bits] =
                inv_sbox_table[shifted[block_bits-1-byte_bits*k -: byte_bits]];
        end
    end

    assign keyed = subbed ^ round_key;

    // ========================================================================
    // InvMixColumns applied after the key is added
    // ========================================================================

    always_comb
    begin
        for (int c = 0; c < 4; c++)
        begin
            mixed[block_bits-1-word_bits*c -: word_bits] =
                inv_mix_column(keyed[block_bits-1-word_bits*c -: word_bits]);
        end
    end

    always_comb
    begin
        case (ctrl.phase)
            phase_load:
                next_state = ciphertext ^ round_key;
            phase_middle:
                next_state = mixed;
            // Idle output is ignored by the state store
            phase_final, phase_idle:
                next_state = keyed;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/aes_state_store.sv
`timescale 1ns/1ps
`default_nettype none

module aes_state_store
    import aes_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  round_ctrl_t ctrl,
    input  block_t      next_state,
    output block_t      state,
    output block_t      plaintext,
    output logic        done
);

    // ========================================================================
    // State, result and completion flag
    // ========================================================================

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state     <= '0;
            plaintext <= '0;
            done      <= 1'b0;
        end
        else
        begin
            case (ctrl.phase)
                phase_load, phase_middle:
                begin
                    state <= next_state;
                end
                phase_final:
                begin
                    plaintext <= next_state;
                    done      <= 1'b1;
                end
                // Hold until the next reset
                default:
                begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/aes_inv_cipher.sv
`timescale 1ns/1ps
`default_nettype none

module aes_inv_cipher
    import aes_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  block_t ciphertext,
    input  block_t key,
    output block_t plaintext,
    output logic   done
);

    round_ctrl_t ctrl;
    block_t      round_key;
    block_t      state;
    block_t      next_state;

    // ========================================================================
    // Control, key schedule, round datapath, state store
    // ========================================================================

    aes_round_ctrl u_round_ctrl (
        .clk   (clk),
        .rst_n (rst_n),
        .ctrl  (ctrl)
    );

    // Key is expanded every cycle, so it must stay put until done
    aes_key_schedule u_key_schedule (
        .key       (key),
        .ctrl      (ctrl),
        .round_key (round_key)
    );

    aes_inv_round u_inv_round (
        .state      (state),
        .ciphertext (ciphertext),
        .round_key  (round_key),
        .ctrl       (ctrl),
        .next_state (next_state)
    );

    aes_state_store u_state_store (
        .clk        (clk),
        .rst_n      (rst_n),
        .ctrl       (ctrl),
        .next_state (next_state),
        .state      (state),
        .plaintext  (plaintext),
        .done       (done)
    );

endmodule

`default_nettype wire

//--- sim/aes_inv_cipher_checker.sv
`timescale 1ns/1ps
`default_nettype none

module aes_inv_cipher_checker
    import aes_pkg::*;
(
    input logic   clk,
    input logic   rst_n,
    input block_t plaintext,
    input logic   done
);

    round_idx_t edge_count;

    // ========================================================================
    // Rising edges since reset release that saturate at the done edge
    // ========================================================================

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            edge_count <= '0;
        else if (edge_count != round_idx_t'(num_rounds + 1))
            edge_count <= edge_count + round_idx_t'(1);
    end

    // ========================================================================
    // Properties
    // ========================================================================

    reset_clears: assert property (@(posedge clk) !rst_n |-> (!done && plaintext == '0))
        else $error("done or plaintext not cleared while reset is low");

    first_edge_clear: assert property (@(posedge clk) $rose(rst_n) |-> (!done && plaintext == '0))
        else $error("done or plaintext not clear on the first edge after reset release");

    // done rises on the eleventh edge and never earlier
    latency_exact: assert property (@(posedge clk) disable iff (!rst_n)
        done == (edge_count == round_idx_t'(num_rounds + 1)))
        else $error("done does not match the eleven cycle latency");

    result_hold: assert property (@(posedge clk) disable iff (!rst_n)
        $past(done) |-> (done && $stable(plaintext)))
        else $error("done or plaintext changed after completion");

endmodule

`default_nettype wire

//--- sim/tb_aes_inv_cipher.sv
`timescale 1ns/1ps
`default_nettype none

module tb_aes_inv_cipher
    import aes_pkg::*;
();

    // FIPS-197 Appendix C.1
    localparam block_t c1_key = 128'h000102030405060708090a0b0c0d0e0f;
    localparam block_t c1_ct  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
    localparam block_t c1_pt  = 128'h00112233445566778899aabbccddeeff;

    // FIPS-197 Appendix B
    localparam block_t b_key  = 128'h2b7e151628aed2a6abf7158809cf4f3c;
    localparam block_t b_ct   = 128'h3925841d02dc09fbdc118597196a0b32;
    localparam block_t b_pt   = 128'h3243f6a8885a308d313198a2e0370734;

    localparam int reset_cycles     = 5;
    localparam int max_wait_cycles  = 20;
    localparam int expected_latency = 11;
    localparam int hold_cycles      = 20;

    logic   clk;
    logic   rst_n;
    block_t ciphertext;
    block_t key;
    block_t plaintext;
    logic   done;

    aes_inv_cipher uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .ciphertext (ciphertext),
        .key        (key),
        .plaintext  (plaintext),
        .done       (done)
    );

    bind aes_inv_cipher aes_inv_cipher_checker u_checker (
        .clk       (clk),
        .rst_n     (rst_n),
        .plaintext (plaintext),
        .done      (done)
    );

    always #2 clk = ~clk;

    // ========================================================================
    // Reporting
    // ========================================================================

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped on first failure");
    endtask

    task automatic check_value(input string name, input block_t expected, input block_t actual);
        assert (actual == expected)
        else
            fail_run($sformatf("error at time %0t: %s expected %h, got %h",
                               $time, name, expected, actual));
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        assert (actual == expected)
        else
            fail_run($sformatf("error at time %0t: %s expected %0d, got %0d",
                               $time, name, expected, actual));
    endtask

    // ========================================================================
    // Stimulus
    // ========================================================================

    // Returns on the falling edge where rst_n is released
    task automatic apply_reset();
        @(negedge clk);
        rst_n = 1'b0;
        for (int i = 0; i < reset_cycles; i++)
        begin
            @(negedge clk);
            check_value("done", '0, block_t'(done));
            check_value("plaintext", '0, plaintext);
        end
        rst_n = 1'b1;
    endtask

    // Counts falling edges, so cycles equals the rising edge where done rose
    task automatic wait_for_done(output int cycles);
        cycles = 0;
        while (!done && cycles < max_wait_cycles)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!done)
            fail_run($sformatf("timeout: done stayed low for %0d cycles after reset release",
                               max_wait_cycles));
    endtask

    task automatic decrypt_and_check(input block_t vec_key, input block_t vec_ct,
                                     input block_t vec_pt);
        int cycles;
        key        = vec_key;
        ciphertext = vec_ct;
        apply_reset();
        wait_for_done(cycles);
        check_count("done latency", expected_latency, cycles);
        check_value("plaintext", vec_pt, plaintext);
    endtask

    // New ciphertext after done must not disturb the result
    task automatic hold_after_done(input block_t vec_ct, input block_t vec_pt);
        ciphertext = ~vec_ct;
        for (int i = 0; i < hold_cycles; i++)
        begin
            @(negedge clk);
            check_value("done", block_t'(1'b1), block_t'(done));
        end
        check_value("plaintext", vec_pt, plaintext);
    endtask

    // ========================================================================
    // Test sequence
    // ========================================================================

    initial
    begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        ciphertext = '0;
        key        = '0;

        decrypt_and_check(c1_key, c1_ct, c1_pt);
        hold_after_done(c1_ct, c1_pt);

        // Second reset clears the finished result before the next vector
        decrypt_and_check(b_key, b_ct, b_pt);
        hold_after_done(b_ct, b_pt);

        @(negedge clk);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- aes_inv_cipher.f
logic/aes_pkg.sv
logic/aes_round_ctrl.sv
logic/aes_key_schedule.sv
logic/aes_inv_round.sv
logic/aes_state_store.sv
logic/aes_inv_cipher.sv
sim/aes_inv_cipher_checker.sv
sim/tb_aes_inv_cipher.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the AES inverse cipher testbench with Verilator.
# The exit status is that of the simulation: nonzero on any failure.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_aes_inv_cipher \
    --Mdir obj_dir \
    -f aes_inv_cipher.f \
    && ./obj_dir/Vtb_aes_inv_cipher \
    || exit 1
